// ==== verilog/id_alloc_defs.svh ====
`ifndef ID_ALLOC_DEFS_SVH
`define ID_ALLOC_DEFS_SVH

// ===========================================================================
// Pool geometry
// ===========================================================================

// Identifier width, 32 identifiers in the pool
`define ID_WID 5

// Bits per bit-vector word
`define WORD_WID 8

// Words in the bit vector
`define NUM_WORDS ((1 << `ID_WID) / `WORD_WID)

// Statistics counter width
`define CNT_WID 16

`endif

// ==== verilog/id_alloc_pkg.sv ====
package id_alloc_pkg;

    `include "id_alloc_defs.svh"

    // Flat identifier
    typedef logic [`ID_WID-1:0] id_t;

    // Bit position inside one word
    typedef logic [$clog2(`WORD_WID)-1:0] bit_idx_t;

    // Word position inside the bit vector
    typedef logic [`ID_WID-$clog2(`WORD_WID)-1:0] word_idx_t;

    // One bit-vector word, set bit means in use
    typedef logic [`WORD_WID-1:0] word_t;

    // Same identifier seen flat or split into word and bit
    typedef union packed {
        id_t flat;
        struct packed {
            word_idx_t word_idx;
            bit_idx_t  bit_idx;
        } parts;
    } id_u;

    // Controller states
    typedef enum logic [1:0] {
        INIT,
        IDLE,
        ALLOC_CHK,
        DEALLOC_CHK
    } ctrl_state_e;

endpackage

// ==== verilog/id_stats_pkg.sv ====
package id_stats_pkg;

    `include "id_alloc_defs.svh"

    // One statistics count
    typedef logic [`CNT_WID-1:0] cnt_t;

    // Increment that sticks at all ones
    function automatic cnt_t sat_inc(input cnt_t cnt);
        cnt_t res;
        if (&cnt) begin
            res = cnt;
        end else begin
            res = cnt + 1'b1;
        end
        return res;
    endfunction

endpackage

// ==== verilog/alloc_ctrl.sv ====
`timescale 1ns/100ps

`include "id_alloc_defs.svh"

module alloc_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   en,
    input  logic                   alloc_req,
    input  logic                   dealloc_req,
    input  id_alloc_pkg::id_t      dealloc_id,
    input  logic                   free_any,
    input  logic                   bit_used,
    input  id_alloc_pkg::bit_idx_t free_bit,
    output logic                   init_done,
    output logic                   alloc_rdy,
    output logic                   dealloc_rdy,
    output logic                   err_dealloc,
    output id_alloc_pkg::id_t      alloc_id,
    output id_alloc_pkg::id_t      err_id,
    output logic                   rd_en,
    output logic                   set_en,
    output logic                   clr_en,
    output logic                   init_en,
    output id_alloc_pkg::word_idx_t rd_word_idx,
    output id_alloc_pkg::word_idx_t init_word_idx,
    output id_alloc_pkg::bit_idx_t bit_sel,
    output logic                   alloc_ev,
    output logic                   dealloc_ev,
    output logic                   err_ev
);
    import id_alloc_pkg::*;

    ctrl_state_e state;
    word_idx_t   scan_ptr;
    word_idx_t   init_idx;
    word_idx_t   miss_cnt;
    logic        full;
    id_u         req_id;
    id_u         dealloc_split;
    id_u         alloc_split;
    logic        idle_free;
    logic        dealloc_go;
    logic        alloc_go;

    // ========================================================================
    // Request acceptance
    // ========================================================================

    // Split incoming identifier for the word read
    assign dealloc_split = id_u'(dealloc_id);

    // Hold off while a ready pulse is still out
    assign idle_free  = (state == IDLE) && !alloc_rdy && !dealloc_rdy;
    // Deallocation wins over allocation
    assign dealloc_go = idle_free && dealloc_req;
    assign alloc_go   = idle_free && !dealloc_req && alloc_req && en && !full;

    // Candidate identifier from scan word and lowest free bit
    always_comb begin
        alloc_split.parts.word_idx = scan_ptr;
        alloc_split.parts.bit_idx  = free_bit;
    end

    // Bitmap controls
    assign rd_en         = dealloc_go || alloc_go;
    assign rd_word_idx   = dealloc_go ? dealloc_split.parts.word_idx : scan_ptr;
    assign init_en       = (state == INIT);
    assign init_word_idx = init_idx;
    assign set_en        = (state == ALLOC_CHK) && free_any;
    assign clr_en        = (state == DEALLOC_CHK) && bit_used;
    assign bit_sel       = (state == DEALLOC_CHK) ? req_id.parts.bit_idx : free_bit;

    // Statistics strobes
    assign alloc_ev   = set_en;
    assign dealloc_ev = clr_en;
    assign err_ev     = (state == DEALLOC_CHK) && !bit_used;

    // ========================================================================
    // Control state
    // ========================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= INIT;
            init_idx    <= '0;
            scan_ptr    <= '0;
            miss_cnt    <= '0;
            full        <= 1'b0;
            init_done   <= 1'b0;
            alloc_rdy   <= 1'b0;
            dealloc_rdy <= 1'b0;
            err_dealloc <= 1'b0;
        end else begin
            // Ready and error are single-cycle pulses
            alloc_rdy   <= 1'b0;
            dealloc_rdy <= 1'b0;
            err_dealloc <= 1'b0;
            case (state)
                INIT: begin
                    init_idx <= init_idx + 1'b1;
                    if (init_idx == word_idx_t'(`NUM_WORDS - 1)) begin
                        state     <= IDLE;
                        init_done <= 1'b1;
                    end
                end
                IDLE: begin
                    if (dealloc_go) begin
                        state <= DEALLOC_CHK;
                    end else if (alloc_go) begin
                        state <= ALLOC_CHK;
                    end
                end
                ALLOC_CHK: begin
                    state <= IDLE;
                    if (free_any) begin
                        alloc_rdy <= 1'b1;
                        miss_cnt  <= '0;
                    end else begin
                        // Full word, move on circularly
                        scan_ptr <= scan_ptr + 1'b1;
                        if (miss_cnt == word_idx_t'(`NUM_WORDS - 1)) begin
                            full     <= 1'b1;
                            miss_cnt <= '0;
                        end else begin
                            miss_cnt <= miss_cnt + 1'b1;
                        end
                    end
                end
                DEALLOC_CHK: begin
                    state       <= IDLE;
                    dealloc_rdy <= 1'b1;
                    err_dealloc <= !bit_used;
                    // A freed bit reopens the pool
                    if (bit_used) begin
                        full     <= 1'b0;
                        miss_cnt <= '0;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    // Identifier payloads
    always_ff @(posedge clk) begin
        if (dealloc_go) begin
            req_id <= dealloc_split;
        end
        if (set_en) begin
            alloc_id <= alloc_split.flat;
        end
        if (state == DEALLOC_CHK) begin
            err_id <= req_id.flat;
        end
    end

endmodule

// ==== verilog/id_bitmap.sv ====
`timescale 1ns/100ps

`include "id_alloc_defs.svh"

module id_bitmap (
    input  logic                    clk,
    input  logic                    rd_en,
    input  logic                    set_en,
    input  logic                    clr_en,
    input  logic                    init_en,
    input  id_alloc_pkg::word_idx_t rd_word_idx,
    input  id_alloc_pkg::word_idx_t init_word_idx,
    input  id_alloc_pkg::bit_idx_t  bit_sel,
    output logic                    free_any,
    output logic                    bit_used,
    output id_alloc_pkg::bit_idx_t  free_bit
);
    import id_alloc_pkg::*;

    // ========================================================================
    // Storage
    // ========================================================================

    // Bit vector with one entry per word
    word_t     mem [`NUM_WORDS];

    // Word read last and where it came from
    word_t     rd_word;
    word_idx_t rd_addr;

    // One-hot of the selected bit
    word_t     sel_mask;

    // Held word after set or clear
    word_t     set_word;
    word_t     clr_word;

    assign sel_mask = word_t'(1) << bit_sel;
    assign set_word = rd_word | sel_mask;
    assign clr_word = rd_word & ~sel_mask;

    // ========================================================================
    // Write side
    // ========================================================================

    // Init sweep zeroes a word
    // Set and clear write the held word back to its own address
    always_ff @(posedge clk) begin
        if (init_en) begin
            mem[init_word_idx] <= '0;
        end else if (set_en) begin
            mem[rd_addr] <= set_word;
        end else if (clr_en) begin
            mem[rd_addr] <= clr_word;
        end
    end

    // ========================================================================
    // Read side
    // ========================================================================

    // Registered word read with its address
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_word_idx];
            rd_addr <= rd_word_idx;
        end
    end

    // ========================================================================
    // Word decode
    // ========================================================================

    // Any zero in the held word
    assign free_any = ~&rd_word;

    // State of the selected bit
    assign bit_used = rd_word[bit_sel];

    // Lowest zero bit
    // Walk down so the last hit is the lowest index
    always_comb begin
        free_bit = '0;
        for (int i = `WORD_WID - 1; i >= 0; i--) begin
            if (!rd_word[i]) begin
                free_bit = bit_idx_t'(i);
            end
        end
    end

endmodule

// ==== verilog/alloc_stats.sv ====
`timescale 1ns/100ps

module alloc_stats (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_ev,
    input  logic               dealloc_ev,
    input  logic               err_ev,
    output id_stats_pkg::cnt_t alloc_cnt,
    output id_stats_pkg::cnt_t dealloc_cnt,
    output id_stats_pkg::cnt_t dealloc_err_cnt,
    output id_stats_pkg::cnt_t active_cnt
);
    import id_stats_pkg::*;

    // ========================================================================
    // Event counters
    // ========================================================================

    // Each counter sticks at its maximum
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_cnt       <= '0;
            dealloc_cnt     <= '0;
            dealloc_err_cnt <= '0;
        end else begin
            if (alloc_ev) begin
                alloc_cnt <= sat_inc(alloc_cnt);
            end
            if (dealloc_ev) begin
                dealloc_cnt <= sat_inc(dealloc_cnt);
            end
            if (err_ev) begin
                dealloc_err_cnt <= sat_inc(dealloc_err_cnt);
            end
        end
    end

    // ========================================================================
    // Active identifiers
    // ========================================================================

    // Up on allocation, down on deallocation
    // Both in one cycle cancel out
    always_ff @(posedge clk) begin
        if (rst) begin
            active_cnt <= '0;
        end else if (alloc_ev && !dealloc_ev) begin
            active_cnt <= sat_inc(active_cnt);
        end else if (dealloc_ev && !alloc_ev) begin
            // Never wrap below zero
            if (active_cnt != '0) begin
                active_cnt <= active_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/id_alloc_top.sv ====
`timescale 1ns/100ps

module id_alloc_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               alloc_req,
    input  logic               dealloc_req,
    input  id_alloc_pkg::id_t  dealloc_id,
    output logic               init_done,
    output logic               alloc_rdy,
    output id_alloc_pkg::id_t  alloc_id,
    output logic               dealloc_rdy,
    output logic               err_dealloc,
    output id_alloc_pkg::id_t  err_id,
    output id_stats_pkg::cnt_t alloc_cnt,
    output id_stats_pkg::cnt_t dealloc_cnt,
    output id_stats_pkg::cnt_t dealloc_err_cnt,
    output id_stats_pkg::cnt_t active_cnt
);
    import id_alloc_pkg::*;

    // Controller to bitmap
    logic      rd_en;
    logic      set_en;
    logic      clr_en;
    logic      init_en;
    word_idx_t rd_word_idx;
    word_idx_t init_word_idx;
    bit_idx_t  bit_sel;

    // Bitmap to controller
    logic      free_any;
    logic      bit_used;
    bit_idx_t  free_bit;

    // Controller to statistics
    logic      alloc_ev;
    logic      dealloc_ev;
    logic      err_ev;

    alloc_ctrl u_ctrl (
        .clk, .rst, .en, .alloc_req, .dealloc_req, .dealloc_id,
        .free_any, .bit_used, .free_bit,
        .init_done, .alloc_rdy, .dealloc_rdy, .err_dealloc, .alloc_id, .err_id,
        .rd_en, .set_en, .clr_en, .init_en, .rd_word_idx, .init_word_idx, .bit_sel,
        .alloc_ev, .dealloc_ev, .err_ev
    );

    id_bitmap u_bitmap (
        .clk, .rd_en, .set_en, .clr_en, .init_en,
        .rd_word_idx, .init_word_idx, .bit_sel,
        .free_any, .bit_used, .free_bit
    );

    alloc_stats u_stats (
        .clk, .rst, .alloc_ev, .dealloc_ev, .err_ev,
        .alloc_cnt, .dealloc_cnt, .dealloc_err_cnt, .active_cnt
    );

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held over the first few rising edges
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/id_alloc_tb.sv ====
`timescale 1ns/100ps

`include "id_alloc_defs.svh"

module id_alloc_tb;
    import id_alloc_pkg::*;
    import id_stats_pkg::*;

    // Run limit in clock cycles
    localparam int   MAX_CYCLES = 4000;
    localparam int   POOL       = 1 << `ID_WID;
    localparam cnt_t POOL_CNT   = cnt_t'(POOL);

    logic clk;
    logic rst;
    logic en;
    logic alloc_req;
    logic dealloc_req;
    id_t  dealloc_id;
    logic init_done;
    logic alloc_rdy;
    id_t  alloc_id;
    logic dealloc_rdy;
    logic err_dealloc;
    id_t  err_id;
    cnt_t alloc_cnt;
    cnt_t dealloc_cnt;
    cnt_t dealloc_err_cnt;
    cnt_t active_cnt;

    // Reference model of the pool
    bit   ref_map [POOL];
    int   ref_ptr;
    id_t  exp_alloc_id;
    id_t  exp_dealloc_id;
    logic exp_err;
    cnt_t exp_alloc_cnt;
    cnt_t exp_dealloc_cnt;
    cnt_t exp_err_cnt;
    cnt_t exp_active;
    logic alloc_blocked;

    int   err_cnt   = 0;
    int   cycle_cnt = 0;
    int   seed      = 85;

    tb_clk_gen #(.PERIOD(100), .RST_CYCLES(4)) u_clk_gen (.clk, .rst);

    id_alloc_top UUT (
        .clk, .rst, .en, .alloc_req, .dealloc_req, .dealloc_id,
        .init_done, .alloc_rdy, .alloc_id, .dealloc_rdy, .err_dealloc, .err_id,
        .alloc_cnt, .dealloc_cnt, .dealloc_err_cnt, .active_cnt
    );

    // ========================================================================
    // Checks at the handshake pulses
    // ========================================================================

    // Identifier handed out
    assert property (@(posedge clk) disable iff (rst) alloc_rdy |-> alloc_id == exp_alloc_id)
    else begin
        $display("Error at %0t: alloc_id %0d, expected %0d", $time, alloc_id, exp_alloc_id);
        err_cnt = err_cnt + 1;
    end

    // Outcome of a return
    assert property (@(posedge clk) disable iff (rst)
        dealloc_rdy |-> err_dealloc == exp_err && (!exp_err || err_id == exp_dealloc_id))
    else begin
        $display("Error at %0t: err_dealloc %0b err_id %0d, expected %0b for id %0d",
                 $time, err_dealloc, err_id, exp_err, exp_dealloc_id);
        err_cnt = err_cnt + 1;
    end

    // Error pulse only together with ready
    assert property (@(posedge clk) disable iff (rst) err_dealloc |-> dealloc_rdy)
    else begin
        $display("Error at %0t: err_dealloc high without dealloc_rdy", $time);
        err_cnt = err_cnt + 1;
    end

    // Counters move one cycle after the strobe and are read in the ready cycle
    assert property (@(posedge clk) disable iff (rst) (alloc_rdy || dealloc_rdy) |->
        alloc_cnt == exp_alloc_cnt && dealloc_cnt == exp_dealloc_cnt &&
        dealloc_err_cnt == exp_err_cnt && active_cnt == exp_active)
    else begin
        $display("Error at %0t: counts %0d/%0d/%0d/%0d, expected %0d/%0d/%0d/%0d", $time,
                 alloc_cnt, dealloc_cnt, dealloc_err_cnt, active_cnt,
                 exp_alloc_cnt, exp_dealloc_cnt, exp_err_cnt, exp_active);
        err_cnt = err_cnt + 1;
    end

    // No grant while the pool is full or en is low
    assert property (@(posedge clk) disable iff (rst) alloc_blocked |-> !alloc_rdy)
    else begin
        $display("Error at %0t: alloc_rdy while allocation is blocked", $time);
        err_cnt = err_cnt + 1;
    end

    // ========================================================================
    // Reference model and client tasks
    // ========================================================================

    // Lowest free bit of the scan word
    // Scan moves on circularly past full words
    function automatic void model_alloc(output id_t id);
        int w;
        bit found;
        found = 1'b0;
        id    = '0;
        for (int n = 0; n < `NUM_WORDS; n++) begin
            if (!found) begin
                w = ref_ptr;
                for (int b = 0; b < `WORD_WID; b++) begin
                    if (!found && !ref_map[w * `WORD_WID + b]) begin
                        found = 1'b1;
                        id    = id_t'(w * `WORD_WID + b);
                    end
                end
                if (!found) begin
                    ref_ptr = (ref_ptr + 1) % `NUM_WORDS;
                end
            end
        end
        if (found) begin
            ref_map[id] = 1'b1;
        end
    endfunction

    // Expectations change mid-cycle and requests start at the rising edge
    task automatic alloc_one(output id_t got);
        id_t exp_id;
        @(negedge clk);
        model_alloc(exp_id);
        exp_alloc_id  = exp_id;
        exp_alloc_cnt = exp_alloc_cnt + 1'b1;
        exp_active    = exp_active + 1'b1;
        @(posedge clk);
        alloc_req <= 1'b1;
        do @(posedge clk); while (!alloc_rdy);
        got = alloc_id;
        alloc_req <= 1'b0;
    endtask

    task automatic free_one(input id_t id);
        @(negedge clk);
        exp_dealloc_id = id;
        exp_err        = !ref_map[id];
        if (exp_err) begin
            exp_err_cnt = exp_err_cnt + 1'b1;
        end else begin
            // A real return frees the bit
            ref_map[id]     = 1'b0;
            exp_dealloc_cnt = exp_dealloc_cnt + 1'b1;
            exp_active      = exp_active - 1'b1;
        end
        @(posedge clk);
        dealloc_id  <= id;
        dealloc_req <= 1'b1;
        do @(posedge clk); while (!dealloc_rdy);
        dealloc_req <= 1'b0;
    endtask

    // Held request that must not be granted
    task automatic start_blocked();
        @(negedge clk);
        alloc_blocked = 1'b1;
        @(posedge clk);
        alloc_req <= 1'b1;
    endtask

    task automatic end_blocked();
        @(posedge clk);
        alloc_req <= 1'b0;
        @(negedge clk);
        alloc_blocked = 1'b0;
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s: %s", num, name, (err_cnt == errs_before) ? "PASS" : "FAIL");
    endtask

    // ========================================================================
    // Run limit
    // ========================================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================================================
    // Tests
    // ========================================================================
    initial begin
        id_t got;
        id_t got_b;
        id_t pick;
        bit  picked;
        int  r;
        int  errs;
        en              = 1'b1;
        alloc_req       = 1'b0;
        dealloc_req     = 1'b0;
        dealloc_id      = '0;
        alloc_blocked   = 1'b0;
        ref_ptr         = 0;
        exp_alloc_id    = '0;
        exp_dealloc_id  = '0;
        exp_err         = 1'b0;
        exp_alloc_cnt   = '0;
        exp_dealloc_cnt = '0;
        exp_err_cnt     = '0;
        exp_active      = '0;
        for (int i = 0; i < POOL; i++) begin
            ref_map[i] = 1'b0;
        end

        // Init sweep finishes with counters clear
        errs = err_cnt;
        @(posedge clk);
        while (rst || !init_done) @(posedge clk);
        assert (alloc_cnt == '0 && dealloc_cnt == '0 && dealloc_err_cnt == '0 &&
                active_cnt == '0)
        else begin
            $display("Error at %0t: counts not zero after init", $time);
            err_cnt = err_cnt + 1;
        end
        report_test(1, "reset and init", errs);

        // One identifier out and back
        errs = err_cnt;
        alloc_one(got);
        assert (got == '0)
        else begin
            $display("Error at %0t: first identifier %0d, expected 0", $time, got);
            err_cnt = err_cnt + 1;
        end
        free_one(got);
        report_test(2, "single alloc and free", errs);

        // Drain the pool and hold a request that stays unanswered
        errs = err_cnt;
        for (int i = 0; i < POOL; i++) begin
            alloc_one(got);
            assert (got == id_t'(i))
            else begin
                $display("Error at %0t: identifier %0d, expected %0d", $time, got, i);
                err_cnt = err_cnt + 1;
            end
        end
        start_blocked();
        repeat (200) @(posedge clk);
        end_blocked();
        for (int i = 0; i < POOL; i++) begin
            free_one(id_t'(i));
        end
        report_test(3, "full pool", errs);

        // Return of an identifier that is already free
        errs = err_cnt;
        free_one(id_t'(9));
        report_test(4, "double free", errs);

        // Low en stops grants only
        errs = err_cnt;
        alloc_one(got);
        alloc_one(got_b);
        @(posedge clk);
        en <= 1'b0;
        start_blocked();
        repeat (20) @(posedge clk);
        free_one(got);
        free_one(got_b);
        end_blocked();
        @(posedge clk);
        en <= 1'b1;
        report_test(5, "enable gating", errs);

        // Random mix with some returns aimed at free identifiers
        errs = err_cnt;
        for (int i = 0; i < 150; i++) begin
            r = $random(seed);
            if (exp_active == '0 || (exp_active < POOL_CNT && r[0])) begin
                alloc_one(got);
            end else begin
                pick   = id_t'(r[7:3]);
                picked = 1'b0;
                if (r[2:1] != 2'b00) begin
                    for (int k = 0; k < POOL; k++) begin
                        if (!picked && ref_map[(r[7:3] + k) % POOL]) begin
                            pick   = id_t'((r[7:3] + k) % POOL);
                            picked = 1'b1;
                        end
                    end
                end
                free_one(pick);
            end
        end
        report_test(6, "random interleave", errs);

        repeat (2) @(posedge clk);
        $display("Summary: 6 tests run, %0d checks failed, %0d cycles", err_cnt, cycle_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== id_alloc.f ====
+incdir+verilog
verilog/id_alloc_pkg.sv
verilog/id_stats_pkg.sv
verilog/alloc_ctrl.sv
verilog/id_bitmap.sv
verilog/alloc_stats.sv
verilog/id_alloc_top.sv
tests/tb_clk_gen.sv
tests/id_alloc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the id_alloc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
FAIL_MSG="Test failed"

verilator --binary --timing --assert -j 0 \
    --top-module id_alloc_tb -Mdir "$OBJ" -f id_alloc.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vid_alloc_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
